// ==== include/set_ops_cfg.svh ====
// sizing macros: lane count, window width, field width, store depth, config FIFO depth
`ifndef SET_OPS_CFG_SVH
`define SET_OPS_CFG_SVH

// --------------------
// lane structure
// --------------------

// number of set-ops lanes sharing the store
`define SET_OPS_NUM_LANES 2

// configuration words per lane window
`define SET_OPS_SEQ_WIDTH 4

// --------------------
// datapath and storage
// --------------------

// operand set, mask and store word width
`define SET_OPS_FIELD_BITS 8

// store words, addressed with 4 bits
`define SET_OPS_STORE_DEPTH 16

// entries in each lane's config FIFO
`define SET_OPS_CFG_FIFO_DEPTH 2

`endif

// ==== project.f ====
+incdir+include
src/set_ops_pkg.sv
src/config_word_store.sv
src/config_mem_arbiter.sv
src/engine_config_fetch.sv
src/engine_set_ops_configure.sv
src/set_ops_engine.sv
src/set_ops_top.sv
verif/set_ops_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the set-ops testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module set_ops_tb -o set_ops_sim

output=$(./obj_dir/set_ops_sim)
echo "$output"

if echo "$output" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== src/config_mem_arbiter.sv ====
// module config_mem_arbiter: round-robin four-phase arbiter over the store, response broadcast
`timescale 1ns/10ps
`include "set_ops_cfg.svh"

module config_mem_arbiter (
    input  logic                                                  ap_clk,
    input  logic                                                  areset_fifo,
    input  logic [`SET_OPS_NUM_LANES-1:0]                         req,
    input  set_ops_pkg::MemoryRequest [`SET_OPS_NUM_LANES-1:0]    request_in,
    output logic [`SET_OPS_NUM_LANES-1:0]                         ack,
    output logic                                                  store_rd_en,
    output logic [$clog2(`SET_OPS_STORE_DEPTH)-1:0]               store_rd_addr,
    input  logic [`SET_OPS_FIELD_BITS-1:0]                        store_rd_data,
    output set_ops_pkg::MemoryPacketResponse                      response_out
);

    localparam int NUM_LANES = `SET_OPS_NUM_LANES;
    localparam int LANE_BITS = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic                   grant_active;
    logic [LANE_BITS-1:0]   grant_lane;
    logic                   read_done;
    logic [LANE_BITS-1:0]   rr_ptr;
    logic                   pick_found;
    logic [LANE_BITS-1:0]   pick_lane;
    logic                   resp_valid;
    set_ops_pkg::type_offset resp_offset;

    // --------------------
    // round-robin pick
    // --------------------
    always_comb begin
        int idx;
        pick_found = 1'b0;
        pick_lane  = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            idx = (int'(rr_ptr) + i) % NUM_LANES;
            if (!pick_found && req[idx]) begin
                pick_found = 1'b1;
                pick_lane  = LANE_BITS'(idx);
            end
        end
    end

    // read once per grant, while the ack is still low
    assign store_rd_en   = grant_active & ~read_done;
    assign store_rd_addr = request_in[grant_lane].offset;

    // --------------------
    // grant and four-phase ack
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            grant_active <= 1'b0;
            grant_lane   <= '0;
            read_done    <= 1'b0;
            rr_ptr       <= '0;
            ack          <= '0;
            resp_valid   <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            if (!grant_active) begin
                if (pick_found) begin
                    grant_active <= 1'b1;
                    grant_lane   <= pick_lane;
                    read_done    <= 1'b0;
                end
            end else if (!read_done) begin
                // word lands in rd_data on this edge
                read_done       <= 1'b1;
                ack[grant_lane] <= 1'b1;
                resp_valid      <= 1'b1;
            end else if (!req[grant_lane]) begin
                ack[grant_lane] <= 1'b0;
                grant_active    <= 1'b0;
                rr_ptr          <= (int'(grant_lane) == NUM_LANES - 1) ? '0 : grant_lane + 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (store_rd_en) begin
            resp_offset <= store_rd_addr;
        end
    end

    // one-cycle packet seen by every lane
    assign response_out.valid  = resp_valid;
    assign response_out.offset = resp_offset;
    assign response_out.data   = store_rd_data;

endmodule

// ==== src/config_word_store.sv ====
// module config_word_store: host-written word array with one registered read port
`timescale 1ns/10ps
`include "set_ops_cfg.svh"

module config_word_store (
    input  logic                                    ap_clk,
    input  logic                                    wr_en,
    input  logic [$clog2(`SET_OPS_STORE_DEPTH)-1:0] wr_addr,
    input  logic [`SET_OPS_FIELD_BITS-1:0]          wr_data,
    input  logic                                    rd_en,
    input  logic [$clog2(`SET_OPS_STORE_DEPTH)-1:0] rd_addr,
    output logic [`SET_OPS_FIELD_BITS-1:0]          rd_data
);

    logic [`SET_OPS_FIELD_BITS-1:0] mem [`SET_OPS_STORE_DEPTH];

    // host side, one word per cycle
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // arbiter side, data one cycle after the address
    always_ff @(posedge ap_clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== src/engine_config_fetch.sv ====
// module engine_config_fetch: per-lane window walker with four-phase req/ack
`timescale 1ns/10ps
`include "set_ops_cfg.svh"

module engine_config_fetch #(
    parameter int LANE_ID = 0
) (
    input  logic                      ap_clk,
    input  logic                      areset_fifo,
    input  logic                      start,
    output logic                      req,
    output set_ops_pkg::MemoryRequest request_out,
    input  logic                      ack,
    output logic                      busy
);

    localparam int SEQ_WIDTH = `SET_OPS_SEQ_WIDTH;
    localparam int SEQ_MIN   = LANE_ID * SEQ_WIDTH;

    set_ops_pkg::fetch_state         state;
    logic [$clog2(SEQ_WIDTH)-1:0]    word_cnt;

    // offset held stable while req is up
    assign request_out.offset = set_ops_pkg::type_offset'(SEQ_MIN) + word_cnt;
    assign busy               = (state != set_ops_pkg::fetch_idle);

    // --------------------
    // handshake FSM
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            state    <= set_ops_pkg::fetch_idle;
            req      <= 1'b0;
            word_cnt <= '0;
        end else begin
            case (state)
                set_ops_pkg::fetch_idle: begin
                    if (start) begin
                        word_cnt <= '0;
                        req      <= 1'b1;
                        state    <= set_ops_pkg::fetch_req;
                    end
                end
                set_ops_pkg::fetch_req: begin
                    // word delivered, release the request
                    if (ack) begin
                        req   <= 1'b0;
                        state <= set_ops_pkg::fetch_wait_release;
                    end
                end
                set_ops_pkg::fetch_wait_release: begin
                    if (!ack) begin
                        if (int'(word_cnt) == SEQ_WIDTH - 1) begin
                            state <= set_ops_pkg::fetch_idle;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            req      <= 1'b1;
                            state    <= set_ops_pkg::fetch_req;
                        end
                    end
                end
                default: begin
                    state <= set_ops_pkg::fetch_idle;
                end
            endcase
        end
    end

endmodule

// ==== src/engine_set_ops_configure.sv ====
// module engine_set_ops_configure: window filter, sequence tracker, config assembly, config FIFO
`timescale 1ns/10ps
`include "set_ops_cfg.svh"

module engine_set_ops_configure #(
    parameter int LANE_ID = 0
) (
    input  logic                             ap_clk,
    input  logic                             areset_fifo,
    input  set_ops_pkg::MemoryPacketResponse response_in,
    input  logic                             rd_en,
    output set_ops_pkg::SetOpsConfiguration  configure_out,
    output logic                             empty,
    output logic                             setup
);

    localparam int SEQ_WIDTH = `SET_OPS_SEQ_WIDTH;
    localparam int SEQ_MIN   = LANE_ID * SEQ_WIDTH;
    localparam int SEQ_MAX   = SEQ_MIN + SEQ_WIDTH;
    localparam int DEPTH     = `SET_OPS_CFG_FIFO_DEPTH;
    localparam int PTR_BITS  = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic                                   areset_reg;
    set_ops_pkg::MemoryPacketResponse       resp_reg;
    set_ops_pkg::MemoryPacketResponse       win_reg;
    logic                                   in_window;
    logic [SEQ_WIDTH-1:0]                   seq_reg;
    logic                                   seq_done;
    logic                                   push_valid;
    set_ops_pkg::SetOpsConfigurationPayload cfg_payload;
    set_ops_pkg::SetOpsConfigurationPayload fifo_mem [DEPTH];
    logic [PTR_BITS-1:0]                    wr_ptr;
    logic [PTR_BITS-1:0]                    rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]             fifo_count;
    logic                                   push;
    logic                                   pop;

    // local copy of reset, setup trails it by one more cycle
    always_ff @(posedge ap_clk) begin
        areset_reg <= areset_fifo;
        setup      <= areset_reg;
    end

    // --------------------
    // input and filter
    // --------------------
    always_ff @(posedge ap_clk) begin
        resp_reg.offset <= response_in.offset;
        resp_reg.data   <= response_in.data;
        win_reg.offset  <= resp_reg.offset;
        win_reg.data    <= resp_reg.data;
        if (areset_reg) begin
            resp_reg.valid <= 1'b0;
            win_reg.valid  <= 1'b0;
        end else begin
            resp_reg.valid <= response_in.valid;
            win_reg.valid  <= in_window;
        end
    end

    assign in_window = resp_reg.valid && (int'(resp_reg.offset) >= SEQ_MIN)
                       && (int'(resp_reg.offset) < SEQ_MAX);

    // --------------------
    // sequence tracking
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_reg) begin
            seq_reg    <= '0;
            seq_done   <= 1'b0;
            push_valid <= 1'b0;
        end else begin
            seq_done   <= seq_reg[SEQ_WIDTH-1] & ~seq_done;
            push_valid <= seq_done;
            if (in_window) begin
                if (int'(resp_reg.offset) == SEQ_MIN && seq_reg == '0) begin
                    seq_reg <= SEQ_WIDTH'(1);
                end else begin
                    seq_reg <= seq_reg << 1;
                end
            end else if (seq_done) begin
                seq_reg <= '0;
            end
        end
    end

    // word 0 is the mask, word 1 the opcode, the rest reserved
    always_ff @(posedge ap_clk) begin
        if (win_reg.valid) begin
            case (seq_reg)
                SEQ_WIDTH'(1): cfg_payload.set_mask <= win_reg.data;
                SEQ_WIDTH'(2): begin
                    cfg_payload.set_operation <=
                        set_ops_pkg::type_set_operation'(win_reg.data[1:0]);
                end
                default: ;
            endcase
        end
    end

    // --------------------
    // config FIFO
    // --------------------
    assign empty = (fifo_count == '0);
    assign push  = push_valid && (int'(fifo_count) != DEPTH);
    assign pop   = rd_en && !empty;

    always_ff @(posedge ap_clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= cfg_payload;
        end
    end

    always_ff @(posedge ap_clk) begin
        configure_out.payload <= fifo_mem[rd_ptr];
        if (areset_reg) begin
            wr_ptr              <= '0;
            rd_ptr              <= '0;
            fifo_count          <= '0;
            configure_out.valid <= 1'b0;
        end else begin
            configure_out.valid <= pop;
            if (push) begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            fifo_count <= fifo_count + push - pop;
        end
    end

endmodule

// ==== src/set_ops_engine.sv ====
// module set_ops_engine: config loader and masked set operation datapath
`timescale 1ns/10ps
`include "set_ops_cfg.svh"

module set_ops_engine (
    input  logic                            ap_clk,
    input  logic                            areset_fifo,
    input  set_ops_pkg::SetOpsConfiguration configure_in,
    input  logic                            empty,
    output logic                            rd_en,
    input  set_ops_pkg::OperandPair         operand_in,
    output set_ops_pkg::SetResult           result_out,
    output logic                            configured
);

    set_ops_pkg::SetOpsConfigurationPayload cfg_reg;
    logic [`SET_OPS_FIELD_BITS-1:0]         op_set;

    // always drain, a newer config replaces the current one
    assign rd_en = ~empty;

    // --------------------
    // config load
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (configure_in.valid) begin
            cfg_reg <= configure_in.payload;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            configured <= 1'b0;
        end else if (configure_in.valid) begin
            configured <= 1'b1;
        end
    end

    // --------------------
    // set operation
    // --------------------
    always_comb begin
        case (cfg_reg.set_operation)
            set_ops_pkg::set_and:  op_set = operand_in.set_a & operand_in.set_b;
            set_ops_pkg::set_or:   op_set = operand_in.set_a | operand_in.set_b;
            set_ops_pkg::set_xor:  op_set = operand_in.set_a ^ operand_in.set_b;
            set_ops_pkg::set_andn: op_set = operand_in.set_a & ~operand_in.set_b;
            default:               op_set = '0;
        endcase
    end

    // result one cycle after the operand pair
    always_ff @(posedge ap_clk) begin
        result_out.result <= op_set & cfg_reg.set_mask;
        if (areset_fifo) begin
            result_out.valid <= 1'b0;
        end else begin
            result_out.valid <= operand_in.valid;
        end
    end

endmodule

// ==== src/set_ops_pkg.sv ====
// package set_ops_pkg: opcode and fetch state enums, request, response, config and operand structs
`include "set_ops_cfg.svh"

package set_ops_pkg;

    // --------------------
    // scalar types
    // --------------------
    typedef logic [$clog2(`SET_OPS_STORE_DEPTH)-1:0] type_offset;
    typedef logic [`SET_OPS_FIELD_BITS-1:0] type_field;

    typedef enum logic [1:0] {
        set_and,
        set_or,
        set_xor,
        set_andn
    } type_set_operation;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_req,
        fetch_wait_release
    } fetch_state;

    // --------------------
    // memory side
    // --------------------
    typedef struct packed {
        type_offset offset;
    } MemoryRequest;

    typedef struct packed {
        logic       valid;
        type_offset offset;
        type_field  data;
    } MemoryPacketResponse;

    // --------------------
    // engine side
    // --------------------
    typedef struct packed {
        type_field         set_mask;
        type_set_operation set_operation;
    } SetOpsConfigurationPayload;

    typedef struct packed {
        logic                      valid;
        SetOpsConfigurationPayload payload;
    } SetOpsConfiguration;

    typedef struct packed {
        logic      valid;
        type_field set_a;
        type_field set_b;
    } OperandPair;

    typedef struct packed {
        logic      valid;
        type_field result;
    } SetResult;

endpackage

// ==== src/set_ops_top.sv ====
// module set_ops_top: store, arbiter and per-lane fetch, configure and engine instances
`timescale 1ns/10ps
`include "set_ops_cfg.svh"

module set_ops_top (
    input  logic                                            ap_clk,
    input  logic                                            areset_fifo,
    input  logic                                            start,
    input  logic                                            cfg_wr_en,
    input  logic [$clog2(`SET_OPS_STORE_DEPTH)-1:0]         cfg_wr_addr,
    input  logic [`SET_OPS_FIELD_BITS-1:0]                  cfg_wr_data,
    input  set_ops_pkg::OperandPair [`SET_OPS_NUM_LANES-1:0] operand_in,
    output set_ops_pkg::SetResult [`SET_OPS_NUM_LANES-1:0]   result_out,
    output logic [`SET_OPS_NUM_LANES-1:0]                   configured,
    output logic [`SET_OPS_NUM_LANES-1:0]                   busy,
    output logic [`SET_OPS_NUM_LANES-1:0]                   setup
);

    logic [`SET_OPS_NUM_LANES-1:0]                          req;
    logic [`SET_OPS_NUM_LANES-1:0]                          ack;
    set_ops_pkg::MemoryRequest [`SET_OPS_NUM_LANES-1:0]     request;
    logic                                                   store_rd_en;
    logic [$clog2(`SET_OPS_STORE_DEPTH)-1:0]                store_rd_addr;
    logic [`SET_OPS_FIELD_BITS-1:0]                         store_rd_data;
    set_ops_pkg::MemoryPacketResponse                       response;
    set_ops_pkg::SetOpsConfiguration [`SET_OPS_NUM_LANES-1:0] cfg_bus;
    logic [`SET_OPS_NUM_LANES-1:0]                          cfg_empty;
    logic [`SET_OPS_NUM_LANES-1:0]                          cfg_rd_en;

    config_word_store store0 (
        .ap_clk  (ap_clk),
        .wr_en   (cfg_wr_en),
        .wr_addr (cfg_wr_addr),
        .wr_data (cfg_wr_data),
        .rd_en   (store_rd_en),
        .rd_addr (store_rd_addr),
        .rd_data (store_rd_data)
    );

    config_mem_arbiter arb0 (
        .ap_clk        (ap_clk),
        .areset_fifo   (areset_fifo),
        .req           (req),
        .request_in    (request),
        .ack           (ack),
        .store_rd_en   (store_rd_en),
        .store_rd_addr (store_rd_addr),
        .store_rd_data (store_rd_data),
        .response_out  (response)
    );

    // --------------------
    // lanes
    // --------------------
    for (genvar i = 0; i < `SET_OPS_NUM_LANES; i++) begin : gen_lane
        engine_config_fetch #(.LANE_ID(i)) fetch0 (
            .ap_clk      (ap_clk),
            .areset_fifo (areset_fifo),
            .start       (start),
            .req         (req[i]),
            .request_out (request[i]),
            .ack         (ack[i]),
            .busy        (busy[i])
        );

        engine_set_ops_configure #(.LANE_ID(i)) configure0 (
            .ap_clk        (ap_clk),
            .areset_fifo   (areset_fifo),
            .response_in   (response),
            .rd_en         (cfg_rd_en[i]),
            .configure_out (cfg_bus[i]),
            .empty         (cfg_empty[i]),
            .setup         (setup[i])
        );

        set_ops_engine engine0 (
            .ap_clk       (ap_clk),
            .areset_fifo  (areset_fifo),
            .configure_in (cfg_bus[i]),
            .empty        (cfg_empty[i]),
            .rd_en        (cfg_rd_en[i]),
            .operand_in   (operand_in[i]),
            .result_out   (result_out[i]),
            .configured   (configured[i])
        );
    end

endmodule

// ==== verif/set_ops_tb.sv ====
// testbench top: clock, reset, host writes, operand stimulus, result checks, timeout
`timescale 1ns/10ps
`include "set_ops_cfg.svh"

module set_ops_tb;

    localparam int NUM_LANES      = `SET_OPS_NUM_LANES;
    localparam int SEQ_WIDTH      = `SET_OPS_SEQ_WIDTH;
    localparam int ADDR_BITS      = $clog2(`SET_OPS_STORE_DEPTH);
    // about 7 loads of ~60 cycles plus ~200 operand cycles, with margin
    localparam int TIMEOUT_CYCLES = 4000;
    // config reaches the engine 4 edges after busy falls
    localparam int CONFIG_SETTLE  = 6;
    localparam int OPS_PER_RUN    = 24;

    logic                                    ap_clk;
    logic                                    areset_fifo;
    logic                                    start;
    logic                                    cfg_wr_en;
    logic [ADDR_BITS-1:0]                    cfg_wr_addr;
    logic [`SET_OPS_FIELD_BITS-1:0]          cfg_wr_data;
    set_ops_pkg::OperandPair [NUM_LANES-1:0] operand_in;
    set_ops_pkg::SetResult [NUM_LANES-1:0]   result_out;
    logic [NUM_LANES-1:0]                    configured;
    logic [NUM_LANES-1:0]                    busy;
    logic [NUM_LANES-1:0]                    setup;

    // reference copy of the store, written alongside the host writes
    logic [`SET_OPS_FIELD_BITS-1:0] store_model [`SET_OPS_STORE_DEPTH];
    integer seed;
    int     error_count = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     cycle_count = 0;
    string  waiting_on = "reset";

    set_ops_top dut0 (
        .ap_clk      (ap_clk),
        .areset_fifo (areset_fifo),
        .start       (start),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_wr_addr (cfg_wr_addr),
        .cfg_wr_data (cfg_wr_data),
        .operand_in  (operand_in),
        .result_out  (result_out),
        .configured  (configured),
        .busy        (busy),
        .setup       (setup)
    );

    always #4 ap_clk = ~ap_clk;

    always @(posedge ap_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles while waiting for %s", cycle_count, waiting_on);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // --------------------
    // checks and models
    // --------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_condition(input bit ok, input string what);
        assert (ok) else begin
            $display("error at %0t: %s", $time, what);
            error_count++;
        end
    endtask

    // and, or, xor, and-not, then the mask
    function automatic logic [7:0] expected_result(input logic [1:0] op, input logic [7:0] a,
                                                   input logic [7:0] b, input logic [7:0] mask);
        logic [7:0] r;
        case (op)
            2'd0:    r = a & b;
            2'd1:    r = a | b;
            2'd2:    r = a ^ b;
            default: r = a & ~b;
        endcase
        return r & mask;
    endfunction

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, error_count - errors_before);
        end
    endtask

    // --------------------
    // stimulus
    // --------------------
    task automatic write_word(input int addr, input logic [7:0] data);
        @(posedge ap_clk);
        #1;
        cfg_wr_en   = 1'b1;
        cfg_wr_addr = ADDR_BITS'(addr);
        cfg_wr_data = data;
        store_model[addr] = data;
    endtask

    task automatic load_lane(input int lane, input logic [7:0] mask, input logic [7:0] op_word,
                             input logic [7:0] rsv2, input logic [7:0] rsv3);
        write_word(lane * SEQ_WIDTH, mask);
        write_word(lane * SEQ_WIDTH + 1, op_word);
        write_word(lane * SEQ_WIDTH + 2, rsv2);
        write_word(lane * SEQ_WIDTH + 3, rsv3);
    endtask

    task automatic pulse_start();
        @(posedge ap_clk);
        #1;
        cfg_wr_en = 1'b0;
        start     = 1'b1;
        @(posedge ap_clk);
        #1;
        start = 1'b0;
        check_value("busy", 2'b11, busy);
    endtask

    task automatic fetch_and_settle();
        pulse_start();
        waiting_on = "busy to fall";
        while (busy != '0) begin
            @(posedge ap_clk);
            #1;
        end
        repeat (CONFIG_SETTLE) @(posedge ap_clk);
        #1;
    endtask

    task automatic await_configured();
        waiting_on = "configured";
        while (configured != '1) begin
            @(posedge ap_clk);
            #1;
        end
    endtask

    // random pairs on both lanes, each result checked one cycle later
    task automatic run_operands(input int count);
        logic [1:0]  op [NUM_LANES];
        logic [7:0]  mask [NUM_LANES];
        logic        exp_valid [NUM_LANES];
        logic [7:0]  exp_data [NUM_LANES];
        logic [31:0] rnd;
        waiting_on = "operand results";
        for (int l = 0; l < NUM_LANES; l++) begin
            mask[l]      = store_model[l * SEQ_WIDTH];
            op[l]        = store_model[l * SEQ_WIDTH + 1][1:0];
            exp_valid[l] = 1'b0;
            exp_data[l]  = '0;
        end
        for (int c = 0; c <= count; c++) begin
            @(posedge ap_clk);
            #1;
            for (int l = 0; l < NUM_LANES; l++) begin
                check_value($sformatf("result_out[%0d].valid", l), exp_valid[l],
                            result_out[l].valid);
                if (exp_valid[l]) begin
                    check_value($sformatf("result_out[%0d].result", l), exp_data[l],
                                result_out[l].result);
                end
                rnd = $random(seed);
                operand_in[l].valid = (c < count) && (rnd[1:0] != 2'b00);
                operand_in[l].set_a = rnd[15:8];
                operand_in[l].set_b = rnd[23:16];
                exp_valid[l] = operand_in[l].valid;
                exp_data[l]  = expected_result(op[l], rnd[15:8], rnd[23:16], mask[l]);
            end
        end
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        int          errs;
        logic [31:0] rnd;
        ap_clk      = 1'b0;
        areset_fifo = 1'b1;
        start       = 1'b0;
        cfg_wr_en   = 1'b0;
        cfg_wr_addr = '0;
        cfg_wr_data = '0;
        operand_in  = '0;
        seed        = 32'h52fc84c3;
        repeat (5) @(posedge ap_clk);
        #1;
        areset_fifo = 1'b0;

        // idle state right after reset
        errs = error_count;
        check_value("result_out[0].valid", 0, result_out[0].valid);
        check_value("result_out[1].valid", 0, result_out[1].valid);
        check_value("configured", 0, configured);
        check_value("busy", 0, busy);
        check_value("setup", 2'b11, setup);
        waiting_on = "setup to fall";
        for (int c = 0; c < 4 && setup != '0; c++) begin
            @(posedge ap_clk);
            #1;
        end
        check_condition(setup == '0, "setup stayed high 4 cycles after reset release");
        finish_test("reset state", errs);

        // both windows fetched through the shared arbiter
        errs = error_count;
        rnd = $random(seed);
        load_lane(0, 8'hFF, 8'(set_ops_pkg::set_and), rnd[7:0], rnd[15:8]);
        load_lane(1, 8'h5A, 8'(set_ops_pkg::set_or), rnd[23:16], rnd[31:24]);
        pulse_start();
        await_configured();
        // config lands only after the last word is released
        check_value("busy", 0, busy);
        run_operands(8);
        finish_test("both lanes load", errs);

        errs = error_count;
        for (int op = 0; op < 4; op++) begin
            rnd = $random(seed);
            load_lane(0, rnd[7:0] | 8'h01, 8'(op), rnd[15:8], rnd[23:16]);
            load_lane(1, rnd[31:24] | 8'h80, 8'(3 - op), rnd[23:16], rnd[15:8]);
            fetch_and_settle();
            run_operands(OPS_PER_RUN);
        end
        finish_test("all opcodes", errs);

        // reserved words look like masks and opcodes
        errs = error_count;
        load_lane(0, 8'h3C, 8'(set_ops_pkg::set_xor), 8'h03, 8'hFF);
        load_lane(1, 8'hC3, 8'(set_ops_pkg::set_andn), 8'h00, 8'h01);
        fetch_and_settle();
        run_operands(OPS_PER_RUN);
        finish_test("window filter", errs);

        errs = error_count;
        rnd = $random(seed);
        load_lane(0, 8'h0F, 8'(set_ops_pkg::set_andn), rnd[7:0], rnd[15:8]);
        load_lane(1, 8'hF0, 8'(set_ops_pkg::set_and), rnd[23:16], rnd[31:24]);
        fetch_and_settle();
        run_operands(OPS_PER_RUN);
        finish_test("reconfiguration", errs);

        $display("tests: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
